/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --assert -f rvMultiCore.f --top-module rvMultiCore_tb -o simv \
    && ./obj_dir/simv +verilator+error+limit+100 | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* rvMultiCore.f */
src/rvMultiPkg.sv
src/ctrlBus.sv
src/controlFsm.sv
src/alu.sv
src/regFile.sv
src/datapath.sv
src/rvMultiCore.sv
test/rvMultiCore_checker.sv
test/rvMultiCore_tb.sv

/* src/alu.sv */
`timescale 1ns/100ps

module alu (
    input  rvMultiPkg::aluOp_e op,
    input  rvMultiPkg::word_t  a,
    input  rvMultiPkg::word_t  b,
    output rvMultiPkg::word_t  result,
    output logic               cmpTrue
);
    import rvMultiPkg::*;

    logic [4:0] shamt;
    logic       equal;
    logic       signedLt;
    logic       unsignedLt;

    assign shamt      = b[4:0]; // Only five bits count
    assign equal      = (a == b);
    assign signedLt   = ($signed(a) < $signed(b));
    assign unsignedLt = (a < b);

    always_comb begin
        result  = '0;
        cmpTrue = 1'b0;
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {31'b0, signedLt};
            ALU_SLTU: result = {31'b0, unsignedLt};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_EQ:   cmpTrue = equal;
            ALU_NE:   cmpTrue = !equal;
            ALU_LT:   cmpTrue = signedLt;
            ALU_GE:   cmpTrue = !signedLt;
            ALU_LTU:  cmpTrue = unsignedLt;
            ALU_GEU:  cmpTrue = !unsignedLt;
        endcase
    end

endmodule

/* src/controlFsm.sv */
`timescale 1ns/100ps

module controlFsm (
    input  logic              clk,
    input  logic              reset,
    input  rvMultiPkg::word_t instr,
    input  logic              cmpTrue,
    ctrlBus.ctrl              bus,
    output rvMultiPkg::word_t retiredCount
);
    import rvMultiPkg::*;

    ctrlState_e state;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       altOp;
    logic       writesRd;
    aluOp_e     decodedOp;

    function automatic aluOp_e arithOp(input logic [2:0] f3, input logic alt);
        aluOp_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic aluOp_e branchOp(input logic [2:0] f3);
        aluOp_e op;
        case (f3)
            3'b000:  op = ALU_EQ;
            3'b001:  op = ALU_NE;
            3'b100:  op = ALU_LT;
            3'b101:  op = ALU_GE;
            3'b110:  op = ALU_LTU;
            3'b111:  op = ALU_GEU;
            default: op = ALU_ADD; // Never taken, ALU reports no compare
        endcase
        return op;
    endfunction

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    // ADDI has no subtract form, only SRAI uses bit 30
    assign altOp    = funct7b5 && (opcode == OPC_OP || funct3 == 3'b101);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:     state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE:   state <= WRITEBACK;
                default:   state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.branchTaken <= 1'b0;
        end else if (state == EXECUTE) begin
            bus.branchTaken <= (opcode == OPC_BRANCH) && cmpTrue;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retiredCount <= '0;
        end else if (state == WRITEBACK) begin
            retiredCount <= retiredCount + 32'd1;
        end
    end

    always_comb begin
        writesRd    = 1'b0;
        bus.srcA    = SRC_A_RS1;
        bus.srcB    = SRC_B_RS2;
        bus.wbSel   = WB_ALU;
        bus.immKind = IMM_I;
        decodedOp   = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                writesRd  = 1'b1;
                decodedOp = arithOp(funct3, altOp);
            end
            OPC_OP_IMM: begin
                writesRd  = 1'b1;
                bus.srcB  = SRC_B_IMM;
                decodedOp = arithOp(funct3, altOp);
            end
            OPC_LOAD: begin
                writesRd  = 1'b1;
                bus.srcB  = SRC_B_IMM;
                bus.wbSel = WB_LOAD;
            end
            OPC_STORE: begin
                bus.srcB    = SRC_B_IMM;
                bus.immKind = IMM_S;
            end
            OPC_BRANCH: begin
                bus.immKind = IMM_B;
                decodedOp   = (state == EXECUTE) ? branchOp(funct3) : ALU_ADD;
            end
            OPC_JAL: begin
                writesRd    = 1'b1;
                bus.srcA    = SRC_A_PC; // Target is PC + imm
                bus.srcB    = SRC_B_IMM;
                bus.wbSel   = WB_PC4;
                bus.immKind = IMM_J;
            end
            OPC_JALR: begin
                writesRd  = 1'b1;
                bus.srcB  = SRC_B_IMM;
                bus.wbSel = WB_PC4;
            end
            default: decodedOp = ALU_ADD; // Unknown opcode runs as a no-op
        endcase
    end

    assign bus.aluOp       = decodedOp;
    assign bus.irLoad      = (state == FETCH);
    assign bus.operandLoad = (state == DECODE);
    assign bus.resultLoad  = (state == EXECUTE);
    assign bus.pcWrite     = (state == WRITEBACK);
    assign bus.regWrite    = (state == WRITEBACK) && writesRd;
    assign bus.memWrite    = (state == WRITEBACK) && (opcode == OPC_STORE);

endmodule

/* src/ctrlBus.sv */
`timescale 1ns/100ps

interface ctrlBus;
    import rvMultiPkg::*;

    logic     irLoad;
    logic     pcWrite;
    logic     regWrite;
    logic     memWrite;
    srcA_e    srcA;
    srcB_e    srcB;
    wbSel_e   wbSel;
    immKind_e immKind;
    aluOp_e   aluOp;
    logic     resultLoad;
    logic     operandLoad;
    logic     branchTaken; // Latched at the end of EXECUTE

    modport ctrl (
        output irLoad, pcWrite, regWrite, memWrite, srcA, srcB, wbSel,
               immKind, aluOp, resultLoad, operandLoad, branchTaken
    );

    modport dp (
        input irLoad, pcWrite, regWrite, memWrite, srcA, srcB, wbSel,
              immKind, aluOp, resultLoad, operandLoad, branchTaken
    );

endinterface

/* src/datapath.sv */
`timescale 1ns/100ps

module datapath #(
    parameter rvMultiPkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    ctrlBus.dp                  bus,
    output rvMultiPkg::word_t   instr,
    output rvMultiPkg::word_t   instrAddr,
    input  rvMultiPkg::word_t   instrData,
    output rvMultiPkg::word_t   dataAddr,
    output rvMultiPkg::word_t   dataWdata,
    output logic                dataWe,
    input  rvMultiPkg::word_t   dataRdata,
    output rvMultiPkg::word_t   aluA,
    output rvMultiPkg::word_t   aluB,
    input  rvMultiPkg::word_t   aluResult,
    output rvMultiPkg::regIdx_t rs1,
    output rvMultiPkg::regIdx_t rs2,
    output rvMultiPkg::regIdx_t rd,
    input  rvMultiPkg::word_t   rdata1,
    input  rvMultiPkg::word_t   rdata2,
    output rvMultiPkg::word_t   wdata,
    output logic                regWe
);
    import rvMultiPkg::*;

    word_t pc;
    word_t ir;
    word_t aReg;
    word_t bReg;
    word_t immReg;
    word_t resultReg;
    word_t imm;
    word_t pcPlus4;
    word_t nextPc;

    // Immediate of the selected format
    always_comb begin
        case (bus.immKind)
            IMM_I:   imm = {{20{ir[31]}}, ir[31:20]};
            IMM_S:   imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IMM_B:   imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            default: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.irLoad) begin
            ir <= instrData;
        end
        if (bus.operandLoad) begin
            aReg   <= rdata1;
            bReg   <= rdata2;
            immReg <= imm;
        end
        if (bus.resultLoad) begin
            resultReg <= aluResult;
        end
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (bus.branchTaken) begin
            nextPc = pc + immReg;
        end else if (bus.wbSel == WB_PC4) begin
            nextPc = {resultReg[31:1], 1'b0}; // Jump target from the ALU
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (bus.pcWrite) begin
            pc <= nextPc;
        end
    end

    assign aluA = (bus.srcA == SRC_A_PC) ? pc : aReg;

    always_comb begin
        case (bus.srcB)
            SRC_B_IMM:  aluB = immReg;
            SRC_B_FOUR: aluB = 32'd4;
            default:    aluB = bReg;
        endcase
    end

    always_comb begin
        case (bus.wbSel)
            WB_LOAD: wdata = dataRdata;
            WB_PC4:  wdata = pcPlus4; // Link address
            default: wdata = resultReg;
        endcase
    end

    assign instr     = ir;
    assign instrAddr = pc;
    assign rs1       = ir[19:15];
    assign rs2       = ir[24:20];
    assign rd        = ir[11:7];
    assign regWe     = bus.regWrite;
    assign dataAddr  = resultReg;
    assign dataWdata = bReg;
    assign dataWe    = bus.memWrite;

endmodule

/* src/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                clk,
    input  rvMultiPkg::regIdx_t rs1,
    input  rvMultiPkg::regIdx_t rs2,
    input  rvMultiPkg::regIdx_t rd,
    input  rvMultiPkg::word_t   wdata,
    input  logic                we,
    output rvMultiPkg::word_t   rdata1,
    output rvMultiPkg::word_t   rdata2
);
    import rvMultiPkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* src/rvMultiCore.sv */
`timescale 1ns/100ps

module rvMultiCore #(
    parameter rvMultiPkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output rvMultiPkg::word_t instrAddr,
    input  rvMultiPkg::word_t instrData,
    output rvMultiPkg::word_t dataAddr,
    output rvMultiPkg::word_t dataWdata,
    output logic              dataWe,
    input  rvMultiPkg::word_t dataRdata,
    output rvMultiPkg::word_t retiredCount
);
    import rvMultiPkg::*;

    word_t   instr;
    word_t   aluA;
    word_t   aluB;
    word_t   aluResult;
    logic    cmpTrue;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    word_t   rdata1;
    word_t   rdata2;
    word_t   wdata;
    logic    regWe;

    ctrlBus bus ();

    controlFsm i_controlFsm (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .cmpTrue      (cmpTrue),
        .bus          (bus.ctrl),
        .retiredCount (retiredCount)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus.dp),
        .instr     (instr),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .dataRdata (dataRdata),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluResult (aluResult),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .wdata     (wdata),
        .regWe     (regWe)
    );

    alu i_alu (
        .op      (bus.aluOp),
        .a       (aluA),
        .b       (aluB),
        .result  (aluResult),
        .cmpTrue (cmpTrue)
    );

    regFile i_regFile (
        .clk    (clk),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wdata),
        .we     (regWe),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

/* src/rvMultiPkg.sv */
package rvMultiPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        DECODE    = 2'd1,
        EXECUTE   = 2'd2,
        WRITEBACK = 2'd3
    } ctrlState_e;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_EQ   = 4'd10, // Compare ops only drive cmpTrue
        ALU_NE   = 4'd11,
        ALU_LT   = 4'd12,
        ALU_GE   = 4'd13,
        ALU_LTU  = 4'd14,
        ALU_GEU  = 4'd15
    } aluOp_e;

    typedef enum logic {
        SRC_A_PC  = 1'b0,
        SRC_A_RS1 = 1'b1
    } srcA_e;

    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'd0,
        SRC_B_IMM  = 2'd1,
        SRC_B_FOUR = 2'd2
    } srcB_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2
    } wbSel_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } immKind_e;

endpackage

/* test/rvMultiCore_checker.sv */
`timescale 1ns/100ps

module rvMultiCore_checker (
    input logic                   clk,
    input logic                   reset,
    input rvMultiPkg::ctrlState_e state,
    input logic                   memWrite,
    input logic                   regWrite,
    input rvMultiPkg::word_t      retiredCount
);
    import rvMultiPkg::*;

    int         assertFails = 0;
    logic [1:0] stateBits;

    assign stateBits = state;

    // Reset always lands in FETCH
    resetToFetch: assert property (@(posedge clk) reset |=> state == FETCH)
        else begin
            assertFails++;
            $error("state is not FETCH after reset");
        end

    // Phases step in order and wrap after WRITEBACK
    phaseOrder: assert property (@(posedge clk) !reset |=> stateBits == $past(stateBits) + 2'd1)
        else begin
            assertFails++;
            $error("phase sequence broken");
        end

    // Write strobes belong to the cycle that retires the instruction
    memWriteInWb: assert property (@(posedge clk) disable iff (reset)
        memWrite |=> retiredCount == $past(retiredCount) + 32'd1)
        else begin
            assertFails++;
            $error("memWrite outside WRITEBACK");
        end

    regWriteInWb: assert property (@(posedge clk) disable iff (reset)
        regWrite |=> retiredCount == $past(retiredCount) + 32'd1)
        else begin
            assertFails++;
            $error("regWrite outside WRITEBACK");
        end

endmodule

bind controlFsm rvMultiCore_checker i_checker (
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .memWrite     (bus.memWrite),
    .regWrite     (bus.regWrite),
    .retiredCount (retiredCount)
);

/* test/rvMultiCore_tb.sv */
`timescale 1ns/100ps

module rvMultiCore_tb;
    import rvMultiPkg::*;

    localparam word_t RESET_PC = 32'h0000_0080;

    logic  clk;
    logic  reset;
    word_t instrAddr;
    word_t instrData;
    word_t dataAddr;
    word_t dataWdata;
    logic  dataWe;
    word_t dataRdata;
    word_t retiredCount;

    word_t  imem [0:255];
    word_t  dmem [0:255];
    word_t  mMem [0:255]; // Model copy of data memory
    word_t  mRegs [0:31];
    word_t  mPc;
    integer seed = 32'h4b844d3f;
    int     progIdx;
    word_t  storeOff;
    word_t  haltAddr;
    int     valueErrors = 0;
    int     otherErrors = 0;

    rvMultiCore #(
        .RESET_PC (RESET_PC)
    ) i_rvMultiCore (
        .clk          (clk),
        .reset        (reset),
        .instrAddr    (instrAddr),
        .instrData    (instrData),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataWe       (dataWe),
        .dataRdata    (dataRdata),
        .retiredCount (retiredCount)
    );

    assign instrData = imem[instrAddr[9:2]];
    assign dataRdata = dmem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[9:2]] = dataWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction encoders
    function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2,
                                   input regIdx_t rs1, input logic [2:0] f3, input regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encI(input word_t imm, input regIdx_t rs1, input logic [2:0] f3,
                                   input regIdx_t rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t encS(input word_t imm, input regIdx_t rs2, input regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encB(input word_t imm, input regIdx_t rs2, input regIdx_t rs1,
                                   input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encJ(input word_t imm, input regIdx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input word_t w);
        imem[progIdx] = w;
        progIdx++;
    endtask

    task automatic emitStore(input regIdx_t src);
        emit(encS(storeOff, src, 5'd10));
        storeOff = storeOff + 32'd4;
    endtask

    task automatic emitOp(input logic [6:0] f7, input logic [2:0] f3);
        emit(encR(f7, 5'd3, 5'd2, f3, 5'd5));
        emitStore(5'd5);
    endtask

    task automatic emitOpImm(input logic [2:0] f3, input word_t imm);
        emit(encI(imm, 5'd2, f3, 5'd5, 7'b0010011));
        emitStore(5'd5);
    endtask

    task automatic emitBranch(input logic [2:0] f3, input regIdx_t rs1, input regIdx_t rs2);
        emit(encB(32'd8, rs2, rs1, f3));
        emit(encI(32'd1, 5'd13, 3'b000, 5'd13, 7'b0010011)); // Runs only if not taken
    endtask

    task automatic buildProgram();
        word_t rnd;
        word_t fillAddr;
        for (int i = 0; i < 256; i++) begin
            fillAddr = i * 4;
            imem[i] = {fillAddr[24:0], 7'b0001011}; // Unknown opcode that runs as a no-op
            dmem[i] = $random(seed);
        end
        progIdx  = int'(RESET_PC[9:2]);
        storeOff = '0;
        emit(encI(32'h100, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encI(32'h200, 5'd0, 3'b000, 5'd10, 7'b0010011));
        emit(encI(32'd0, 5'd1, 3'b010, 5'd2, 7'b0000011));
        emit(encI(32'd4, 5'd1, 3'b010, 5'd3, 7'b0000011));
        emit(encI(32'd8, 5'd1, 3'b010, 5'd4, 7'b0000011));
        emitOp(7'b0000000, 3'b000);
        emitOp(7'b0100000, 3'b000);
        emitOp(7'b0000000, 3'b111);
        emitOp(7'b0000000, 3'b110);
        emitOp(7'b0000000, 3'b100);
        emitOp(7'b0000000, 3'b010);
        emitOp(7'b0000000, 3'b011);
        emitOp(7'b0000000, 3'b001);
        emitOp(7'b0000000, 3'b101);
        emitOp(7'b0100000, 3'b101);
        // All ones against zero splits signed from unsigned
        emit(encI(32'hFFFF_FFFF, 5'd0, 3'b000, 5'd6, 7'b0010011));
        emit(encR(7'b0000000, 5'd0, 5'd6, 3'b010, 5'd5));
        emitStore(5'd5);
        emit(encR(7'b0000000, 5'd0, 5'd6, 3'b011, 5'd5));
        emitStore(5'd5);
        emit(encR(7'b0000000, 5'd4, 5'd2, 3'b101, 5'd5));
        emitStore(5'd5);
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            emitOpImm(k < 2 ? 3'(k * 2) : (k < 4 ? 3'(k + 1) : 3'(k + 2)), rnd);
        end
        rnd = $random(seed);
        emitOpImm(3'b001, {27'b0, rnd[4:0]});
        emitOpImm(3'b101, {27'b0, rnd[9:5]});
        emitOpImm(3'b101, {20'b0, 7'b0100000, rnd[14:10]});
        emit(encI(32'd12, 5'd1, 3'b010, 5'd7, 7'b0000011));
        emitStore(5'd7);
        emit(encI(32'd12, 5'd1, 3'b010, 5'd0, 7'b0000011));
        emitStore(5'd0);
        emit(encI(32'd5, 5'd0, 3'b000, 5'd11, 7'b0010011));
        emit(encI(32'hFFFF_FFFD, 5'd0, 3'b000, 5'd12, 7'b0010011));
        emit(encI(32'd0, 5'd0, 3'b000, 5'd13, 7'b0010011));
        emitBranch(3'b000, 5'd11, 5'd11);
        emitBranch(3'b000, 5'd11, 5'd12);
        emitBranch(3'b001, 5'd11, 5'd12);
        emitBranch(3'b001, 5'd11, 5'd11);
        emitBranch(3'b100, 5'd12, 5'd11);
        emitBranch(3'b100, 5'd11, 5'd12);
        emitBranch(3'b101, 5'd11, 5'd12);
        emitBranch(3'b101, 5'd12, 5'd11);
        emitBranch(3'b110, 5'd11, 5'd12);
        emitBranch(3'b110, 5'd12, 5'd11);
        emitBranch(3'b111, 5'd12, 5'd11);
        emitBranch(3'b111, 5'd11, 5'd12);
        emitStore(5'd13);
        emit(encJ(32'd8, 5'd14));
        emit(encI(32'd1, 5'd13, 3'b000, 5'd13, 7'b0010011));
        emitStore(5'd14);
        emit(encI(32'd17, 5'd14, 3'b000, 5'd16, 7'b1100111)); // Odd offset with bit 0 dropped
        emit(encI(32'd1, 5'd13, 3'b000, 5'd13, 7'b0010011));
        emitStore(5'd16);
        emitStore(5'd13);
        haltAddr = {22'b0, 8'(progIdx), 2'b00};
        emit(encJ(32'd0, 5'd0));
    endtask

    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs one instruction on the model state and returns the next fetch address
    function automatic word_t stepModel(output logic isStore, output word_t stAddr,
                                        output word_t stData);
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    immI;
        word_t    res;
        word_t    nextPc;
        logic     taken;
        logic     wr;
        ins     = imem[mPc[9:2]];
        a       = mRegs[ins[19:15]];
        b       = mRegs[ins[24:20]];
        immI    = {{20{ins[31]}}, ins[31:20]};
        res     = '0;
        wr      = 1'b0;
        taken   = 1'b0;
        isStore = 1'b0;
        stAddr  = '0;
        stData  = '0;
        nextPc  = mPc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                res = aluRef(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            7'b0010011: begin
                res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
                wr  = 1'b1;
            end
            7'b0000011: begin
                stAddr = a + immI;
                res    = mMem[stAddr[9:2]];
                stAddr = '0;
                wr     = 1'b1;
            end
            7'b0100011: begin
                isStore = 1'b1;
                stAddr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                stData  = b;
                mMem[stAddr[9:2]] = b;
            end
            7'b1100011: begin
                case (ins[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                res    = mPc + 32'd4;
                wr     = 1'b1;
                nextPc = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res    = mPc + 32'd4;
                wr     = 1'b1;
                nextPc = (a + immI) & ~32'd1;
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            mRegs[ins[11:7]] = res;
        end
        mPc = nextPc;
        return nextPc;
    endfunction

    task automatic checkAddr(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    initial begin
        word_t startCount;
        word_t expectPc;
        word_t stAddr;
        word_t stData;
        logic  isStore;
        logic  sawStore;
        logic  stop;
        logic  halted;
        int    cycles;
        int    steps;
        reset = 1'b1;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            mMem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        mPc = RESET_PC;
        repeat (10) begin
            @(negedge clk);
            if (dataWe !== 1'b0) begin
                otherErrors++;
                $display("Store strobe active during reset");
            end
        end
        reset = 1'b0;
        checkWord("retiredCount after reset", 32'd0, retiredCount);
        expectPc = RESET_PC;
        stop     = 1'b0;
        halted   = 1'b0;
        steps    = 0;
        while (!stop && steps < 200) begin
            checkAddr("fetch address", expectPc, instrAddr);
            if (expectPc == haltAddr) begin
                halted = 1'b1;
                stop   = 1'b1;
            end else begin
                startCount = retiredCount;
                expectPc   = stepModel(isStore, stAddr, stData);
                cycles     = 0;
                sawStore   = 1'b0;
                while (retiredCount == startCount && cycles < 8) begin
                    @(negedge clk);
                    cycles++;
                    if (dataWe) begin
                        sawStore = 1'b1;
                        if (!isStore) begin
                            otherErrors++;
                            $display("Store strobe on an instruction that does not store");
                        end else begin
                            checkAddr("store address", stAddr, dataAddr);
                            checkWord("store data", stData, dataWdata);
                        end
                    end
                end
                if (retiredCount == startCount) begin
                    otherErrors++;
                    $display("Timed out waiting for an instruction to retire");
                    stop = 1'b1;
                end else if (cycles != 4 || retiredCount != startCount + 32'd1) begin
                    otherErrors++;
                    $display("Instruction did not retire after exactly four cycles");
                end
                if (isStore && !sawStore) begin
                    otherErrors++;
                    $display("Expected store never appeared");
                end
                steps++;
            end
        end
        if (!halted) begin
            otherErrors++;
            $display("Program never reached its final loop");
        end
        otherErrors += i_rvMultiCore.i_controlFsm.i_checker.assertFails;
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
